/* common/eeprom_pkg.sv */
package eeprom_pkg;

    // fixed upper nibble of the control byte (24C16 style device)
    localparam logic [3:0] DEVICE_TYPE = 4'b1010;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    typedef enum logic
    {
        DIR_SEND = 1'b0,
        DIR_RECV = 1'b1
    } dir_e;

    // one latched host request
    typedef struct packed
    {
        op_e         op;
        logic [10:0] addr;   // [10:8] page bits, [7:0] word address
        logic [7:0]  wdata;
    } eeprom_req_t;

    // one-cycle pulses, first cycle of each quarter of a bit period
    typedef struct packed
    {
        logic drive;    // scl low, data may change
        logic rise;     // scl goes high
        logic sample;   // middle of high phase
        logic fall;     // scl goes low
    } bit_tick_t;

    // shifter command, load strobe qualifies the rest
    typedef struct packed
    {
        logic       load;
        dir_e       dir;
        logic [7:0] data;   // byte to send
        logic       ack;    // master ack bit for received bytes, 1 = nack
    } shift_cmd_t;

endpackage

/* i2c_master/bit_timer.sv */
`timescale 1ns/1ps

module bit_timer import eeprom_pkg::*;
#(
    parameter int QUARTER = 2
)
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      en,
    output logic      scl,
    output bit_tick_t tick
);

    localparam int CW = (QUARTER > 2) ? $clog2(QUARTER) : 1;
    localparam logic [CW-1:0] LAST = CW'(QUARTER - 1);

    logic [CW-1:0] cnt;     // cycles within a quarter
    logic [1:0]    quarter;
    logic          first;

    // held at zero while disabled, so each enable starts a fresh bit period
    always_ff @(posedge CLK)
    begin
        if (RESET || !en)
        begin
            cnt     <= '0;
            quarter <= 2'd0;
        end
        else if (cnt == LAST)
        begin
            cnt     <= '0;
            quarter <= quarter + 2'd1;
        end
        else
        begin
            cnt <= cnt + CW'(1);
        end
    end

    assign first = en && (cnt == '0);

    // quarter 0 fall, 1 drive, 2 rise, 3 sample
    assign tick.fall   = first && (quarter == 2'd0);
    assign tick.drive  = first && (quarter == 2'd1);
    assign tick.rise   = first && (quarter == 2'd2);
    assign tick.sample = first && (quarter == 2'd3);

    assign scl = !en || quarter[1];   // idle bus keeps scl high

endmodule

/* i2c_master/byte_shifter.sv */
`timescale 1ns/1ps

module byte_shifter import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  shift_cmd_t cmd,
    input  bit_tick_t  tick,
    input  logic       sda_in,
    output logic       line_low,
    output logic       byte_done,
    output logic [7:0] rx_byte,
    output logic       ack_seen
);

    logic [8:0] sh;         // bit 8 goes out next
    logic [8:0] load_val;
    logic [3:0] bit_cnt;    // 8 down to 0, 0 is the ack bit
    logic       active;
    dir_e       dir;

    // sending puts a released bit in the ack slot, receiving keeps the line free
    always_comb
    begin
        if (cmd.dir == DIR_SEND)
            load_val = {cmd.data, 1'b1};
        else
            load_val = {8'hff, cmd.ack};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            bit_cnt   <= 4'd0;
            dir       <= DIR_SEND;
            line_low  <= 1'b0;
            byte_done <= 1'b0;
            ack_seen  <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (cmd.load)   // always lands on a drive tick
            begin
                active   <= 1'b1;
                bit_cnt  <= 4'd8;
                dir      <= cmd.dir;
                line_low <= ~load_val[8];
            end
            else if (tick.drive)
            begin
                if (active)
                begin
                    bit_cnt  <= bit_cnt - 4'd1;
                    line_low <= ~sh[7];
                end
                else
                begin
                    line_low <= 1'b0;   // let go after the ack bit
                end
            end
            else if (tick.sample && active && bit_cnt == 4'd0)
            begin
                byte_done <= 1'b1;
                ack_seen  <= ~sda_in;   // slave holds the line low to ack
                active    <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd.load)
            sh <= load_val;
        else if (tick.drive && active)
            sh <= {sh[7:0], 1'b1};
        // msb first, eight data bits only
        if (tick.sample && active && bit_cnt != 4'd0 && dir == DIR_RECV)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

endmodule

/* i2c_master/i2c_master_fsm.sv */
`timescale 1ns/1ps

module i2c_master_fsm import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    input  eeprom_req_t req,
    input  bit_tick_t   tick,
    input  logic        byte_done,
    input  logic [7:0]  rx_byte,
    input  logic        ack_seen,
    output logic        timer_en,
    output shift_cmd_t  cmd,
    output logic        line_low,
    output logic        busy,
    output logic        done,
    output logic        nack,
    output logic [7:0]  rdata
);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RSTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_FINISH
    } state_e;

    state_e state;
    state_e next_byte;  // where a byte state goes after a good ack
    logic   sent;       // shifter already loaded in this byte state
    logic   byte_state;

    assign byte_state = (state == S_CTRL_W) || (state == S_ADDR) || (state == S_DATA_W)
                     || (state == S_CTRL_R) || (state == S_DATA_R);

    assign busy     = (state != S_IDLE) && (state != S_FINISH);
    assign timer_en = busy;
    assign done     = (state == S_FINISH);

    always_comb
    begin
        cmd      = '0;
        cmd.dir  = DIR_SEND;
        cmd.ack  = 1'b0;
        case (state)
            S_CTRL_W: cmd.data = {DEVICE_TYPE, req.addr[10:8], 1'b0};
            S_ADDR:   cmd.data = req.addr[7:0];
            S_DATA_W: cmd.data = req.wdata;
            S_CTRL_R: cmd.data = {DEVICE_TYPE, req.addr[10:8], 1'b1};
            S_DATA_R:
            begin
                cmd.dir  = DIR_RECV;
                cmd.data = 8'hff;
                cmd.ack  = 1'b1;   // single byte read ends with nack
            end
            default:  cmd.data = 8'hff;
        endcase
        cmd.load = byte_state && tick.drive && !sent;
    end

    always_comb
    begin
        case (state)
            S_CTRL_W: next_byte = S_ADDR;
            S_ADDR:   next_byte = (req.op == OP_READ) ? S_RSTART : S_DATA_W;
            S_CTRL_R: next_byte = S_DATA_R;
            default:  next_byte = S_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            sent     <= 1'b0;
            line_low <= 1'b0;
            nack     <= 1'b0;
            rdata    <= 8'h00;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (req_valid)
                    begin
                        nack  <= 1'b0;
                        state <= S_START;
                    end
                end
                S_START, S_RSTART:
                begin
                    if (tick.sample)
                    begin
                        line_low <= 1'b1;   // falls while scl high
                        state    <= (state == S_START) ? S_CTRL_W : S_CTRL_R;
                    end
                end
                S_CTRL_W, S_ADDR, S_DATA_W, S_CTRL_R:
                begin
                    if (cmd.load)
                    begin
                        sent     <= 1'b1;
                        line_low <= 1'b0;   // shifter owns the line now
                    end
                    else if (byte_done)
                    begin
                        sent <= 1'b0;
                        if (!ack_seen)
                        begin
                            nack  <= 1'b1;
                            state <= S_STOP;
                        end
                        else
                        begin
                            state <= next_byte;
                        end
                    end
                end
                S_DATA_R:
                begin
                    if (cmd.load)
                    begin
                        sent     <= 1'b1;
                        line_low <= 1'b0;
                    end
                    else if (byte_done)
                    begin
                        sent  <= 1'b0;
                        rdata <= rx_byte;
                        state <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    if (tick.drive)
                        line_low <= 1'b1;
                    if (tick.sample)
                    begin
                        line_low <= 1'b0;   // rises while scl high
                        state    <= S_FINISH;
                    end
                end
                S_FINISH:
                begin
                    // busy already low here, a new request may come in
                    if (req_valid)
                    begin
                        nack  <= 1'b0;
                        state <= S_START;
                    end
                    else
                    begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* logic/eeprom_if_top.sv */
`timescale 1ns/1ps

module eeprom_if_top import eeprom_pkg::*;
#(
    parameter int QUARTER = 2
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    input  logic        sda_in,
    output logic [7:0]  rdata,
    output logic        busy,
    output logic        done,
    output logic        nack,
    output logic        scl,
    output logic        sda_oe
);

    eeprom_req_t req_q;
    logic        req_valid;
    logic        timer_en;
    bit_tick_t   tick;
    shift_cmd_t  cmd;
    logic        fsm_low;
    logic        shift_low;
    logic        byte_done;
    logic        ack_seen;
    logic [7:0]  rx_byte;

    // pulses during busy are dropped
    assign req_valid = (wr || rd) && !busy;

    always_ff @(posedge CLK)
    begin
        if (req_valid)
        begin
            req_q.op    <= wr ? OP_WRITE : OP_READ;   // write wins
            req_q.addr  <= addr;
            req_q.wdata <= wdata;
        end
    end

    i2c_master_fsm u_fsm (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req_q),
        .tick      (tick),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen),
        .timer_en  (timer_en),
        .cmd       (cmd),
        .line_low  (fsm_low),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rdata     (rdata)
    );

    bit_timer #(.QUARTER(QUARTER)) u_timer (
        .CLK   (CLK),
        .RESET (RESET),
        .en    (timer_en),
        .scl   (scl),
        .tick  (tick)
    );

    byte_shifter u_shifter (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .tick      (tick),
        .sda_in    (sda_in),
        .line_low  (shift_low),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen)
    );

    assign sda_oe = fsm_low || shift_low;   // start/stop or shifted bits

endmodule

/* run.sh */
#!/bin/sh
# build and run with Verilator, result taken from the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module eeprom_tb \
    -f vlog.f -o eeprom_sim > build.log 2>&1 \
    && ./obj_dir/eeprom_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* verification/eeprom_asserts.sv */
`timescale 1ns/1ps

module eeprom_asserts import eeprom_pkg::*;
(
    input logic      CLK,
    input logic      RESET,
    input logic      scl,
    input logic      sda_oe,
    input logic      busy,
    input logic      done,
    input bit_tick_t tick
);

    // while scl high the line moves only at a start or stop, i.e. on a sample tick
    property line_stable_high;
        @(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_oe)) |-> $past(tick.sample);
    endproperty

    // single cycle, right after the stop released the line
    property done_one_cycle;
        @(posedge CLK) disable iff (RESET)
        done |-> !$past(done) && scl && $past(sda_oe) && !sda_oe;
    endproperty

    property idle_released;
        @(posedge CLK) disable iff (RESET)
        !busy |-> !sda_oe;
    endproperty

    a_line: assert property (line_stable_high) else $error("data line moved while scl high");
    a_done: assert property (done_one_cycle) else $error("done not a single pulse after stop");
    a_idle: assert property (idle_released) else $error("line pulled low while idle");

endmodule

bind eeprom_if_top eeprom_asserts u_asserts
(
    .CLK    (CLK),
    .RESET  (RESET),
    .scl    (scl),
    .sda_oe (sda_oe),
    .busy   (busy),
    .done   (done),
    .tick   (tick)
);

/* verification/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,
    input  logic absent,
    output logic sda_low
);

    localparam int M_IDLE = 0;
    localparam int M_RECV = 1;
    localparam int M_SEND = 2;

    logic [7:0]  mem [0:2047];
    int          mode = M_IDLE;
    int          pos = -1;          // bit index on the bus, 8 is the ack slot
    int          byte_idx = 0;
    logic [7:0]  sh = 8'h00;
    logic [7:0]  tx = 8'h00;
    logic [2:0]  page = 3'd0;
    logic [10:0] ptr = 11'd0;
    logic        send_next = 1'b0;
    logic        low = 1'b0;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ {5'b0, a[10:8]};
    end

    assign sda_low = low && !absent;

    // start and stop, line moves while scl high
    always @(negedge sda)
    begin
        if (scl === 1'b1 && !absent)
        begin
            mode      = M_RECV;
            pos       = -1;
            byte_idx  = 0;
            send_next = 1'b0;
            low       = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode = M_IDLE;
            low  = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (mode == M_RECV && pos >= 0 && pos < 8)
            sh = {sh[6:0], sda};
    end

    always @(negedge scl)
    begin
        if (mode != M_IDLE)
        begin
            pos = (pos == 8) ? 0 : pos + 1;
            if (mode == M_RECV)
            begin
                if (pos == 8)
                begin
                    low = 1'b1;
                    case (byte_idx)
                        0:
                        begin
                            if (sh[7:4] != DEVICE_TYPE)
                            begin
                                low  = 1'b0;   // not addressed
                                mode = M_IDLE;
                            end
                            page      = sh[3:1];
                            send_next = sh[0];
                        end
                        1: ptr = {page, sh};
                        2: mem[ptr] = sh;
                        default: ;
                    endcase
                    byte_idx++;
                end
                else if (pos == 0 && send_next)
                begin
                    mode = M_SEND;
                    tx   = mem[ptr];
                    low  = ~tx[7];
                end
                else
                begin
                    low = 1'b0;
                end
            end
            else if (mode == M_SEND)
            begin
                if (pos == 8)
                    low = 1'b0;             // master drives its ack
                else if (pos == 0)
                begin
                    mode = M_IDLE;          // sequential reads not modeled
                    low  = 1'b0;
                end
                else
                    low = ~tx[7 - pos];
            end
        end
    end

endmodule

/* verification/eeprom_tb.sv */
`timescale 1ns/1ps

module eeprom_tb;

    localparam int QUARTER = 2;
    localparam int N_OPS = 40;
    localparam int BIT_NS = 4 * QUARTER * 4;
    localparam int WATCHDOG_NS = N_OPS * 39 * BIT_NS + 4000;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        busy;
    logic        done;
    logic        nack;
    logic        scl;
    logic        sda_oe;
    logic        absent;
    logic        model_low;
    wire         sda_line = !(sda_oe || model_low);   // open drain bus

    logic [7:0]  shadow [0:2047];
    bit          shadow_ok [0:2047];
    logic [31:0] lfsr = 32'h64eb97c2;
    logic        exp_nack;
    logic        exp_check_rd;
    logic [7:0]  exp_rdata;
    string       test_name;
    int          errors = 0;
    int          err_mark = 0;
    int          tests = 0;
    int          tests_failed = 0;
    int          done_count = 0;

    eeprom_if_top #(.QUARTER(QUARTER)) uut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .sda_in(sda_line), .rdata(rdata), .busy(busy), .done(done), .nack(nack),
        .scl(scl), .sda_oe(sda_oe)
    );

    eeprom_model model (.scl(scl), .sda(sda_line), .absent(absent), .sda_low(model_low));

    always #2 CLK = ~CLK;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [7:0] ref_read(input logic [10:0] a);
        if (shadow_ok[a])
            return shadow[a];
        return a[7:0] ^ {5'b0, a[10:8]};   // initial contents
    endfunction

    always @(negedge CLK)
    begin
        if (!RESET && done)
        begin
            done_count++;
            assert (nack == exp_nack)
            else
            begin
                $display("error %s: nack expected %0b actual %0b", test_name, exp_nack, nack);
                errors++;
            end
            if (exp_check_rd)
                assert (rdata == exp_rdata)
                else
                begin
                    $display("error %s: rdata expected %h actual %h",
                             test_name, exp_rdata, rdata);
                    errors++;
                end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, a transfer never finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic begin_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors != err_mark)
            tests_failed++;
        $display("%s: %s", test_name, (errors == err_mark) ? "ok" : "failed");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp)
        else
        begin
            $display("error %s: %s expected %0b actual %0b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic pulse(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        @(negedge CLK);
        wr = is_wr;
        rd = !is_wr;
        addr = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done();
        while (!done)
            @(negedge CLK);
        @(negedge CLK);
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d, input logic exp_n);
        exp_nack = exp_n;
        exp_check_rd = 1'b0;
        pulse(1'b1, a, d);
        wait_done();
        if (!exp_n)
        begin
            shadow[a] = d;
            shadow_ok[a] = 1'b1;
        end
    endtask

    task automatic read_byte(input logic [10:0] a, input logic exp_n);
        exp_nack = exp_n;
        exp_check_rd = !exp_n;
        exp_rdata = ref_read(a);
        pulse(1'b0, a, 8'h00);
        wait_done();
    endtask

    initial
    begin
        int d0;
        CLK = 1'b0;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        absent = 1'b0;
        exp_nack = 1'b0;
        exp_check_rd = 1'b0;
        exp_rdata = '0;
        for (int i = 0; i < 2048; i++)
            shadow_ok[i] = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        begin_test("reset");
        @(negedge CLK);
        check_bit("scl", 1'b1, scl);
        check_bit("sda_oe", 1'b0, sda_oe);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("nack", 1'b0, nack);
        end_test();

        begin_test("write_read");
        write_byte(11'h2a5, 8'h3c, 1'b0);
        read_byte(11'h2a5, 1'b0);
        end_test();

        begin_test("random");
        for (int i = 0; i < 24; i++)
        begin
            logic        op;
            logic [10:0] a;
            logic [7:0]  d;
            op = 1'(take_bits(1));
            a = 11'(take_bits(11));
            d = 8'(take_bits(8));
            if (op)
                write_byte(a, d, 1'b0);
            else
                read_byte(a, 1'b0);
        end
        end_test();

        begin_test("pages");
        for (int p = 0; p < 4; p++)
            write_byte({p[2:0], 8'h47}, 8'h90 + p[7:0], 1'b0);
        for (int p = 0; p < 4; p++)
            read_byte({p[2:0], 8'h47}, 1'b0);
        end_test();

        begin_test("absent");
        absent = 1'b1;
        write_byte(11'h61e, 8'hc3, 1'b1);
        read_byte(11'h61e, 1'b1);
        absent = 1'b0;
        read_byte(11'h61e, 1'b0);
        end_test();

        begin_test("busy_request");
        d0 = done_count;
        exp_nack = 1'b0;
        exp_check_rd = 1'b0;
        pulse(1'b1, 11'h133, 8'h5a);
        while (!busy)
            @(negedge CLK);
        repeat (10) @(negedge CLK);
        rd = 1'b1;
        addr = 11'h7ff;
        @(negedge CLK);
        rd = 1'b0;
        wait_done();
        shadow[11'h133] = 8'h5a;
        shadow_ok[11'h133] = 1'b1;
        repeat (3 * 4 * QUARTER) @(negedge CLK);
        assert (!busy && done_count == d0 + 1)
        else
        begin
            $display("error %s: read pulse during a busy write started a transfer", test_name);
            errors++;
        end
        read_byte(11'h133, 1'b0);
        end_test();

        $display("tests %0d, failed %0d, errors %0d, done pulses %0d",
                 tests, tests_failed, errors, done_count);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
common/eeprom_pkg.sv
i2c_master/bit_timer.sv
i2c_master/byte_shifter.sv
i2c_master/i2c_master_fsm.sv
logic/eeprom_if_top.sv
verification/eeprom_model.sv
verification/eeprom_asserts.sv
verification/eeprom_tb.sv
